// File: exec_stage_settings.svh
// --------------------
// Widths and encodings for the execute stage.
// Micro-op codes are only unique within one functional unit.
// Conditional branch codes need bits 4:3 at 00, jumps at 10.
// --------------------
`ifndef EXEC_STAGE_SETTINGS_SVH
`define EXEC_STAGE_SETTINGS_SVH

`define EXEC_XLEN           32          // Data word width

// Unit select bit positions ----------
`define EXEC_FU_ALU         0           // Integer ALU
`define EXEC_FU_LSU         1           // Load/store unit
`define EXEC_FU_CFU         2           // Control flow unit
`define EXEC_FU_CSR         3           // CSR access

// ALU micro-ops ----------
`define EXEC_ALU_ADD        5'b00001
`define EXEC_ALU_SUB        5'b00010
`define EXEC_ALU_XOR        5'b00011
`define EXEC_ALU_OR         5'b00100
`define EXEC_ALU_AND        5'b00101
`define EXEC_ALU_SLL        5'b00110
`define EXEC_ALU_SRL        5'b00111
`define EXEC_ALU_SRA        5'b01000
`define EXEC_ALU_SLT        5'b01001
`define EXEC_ALU_SLTU       5'b01010

// Control flow micro-ops ----------
`define EXEC_CFU_BEQ        5'b00001    // Conditional, bits 4:3 = 00
`define EXEC_CFU_BNE        5'b00010
`define EXEC_CFU_BLT        5'b00011
`define EXEC_CFU_BGE        5'b00100
`define EXEC_CFU_BLTU       5'b00101
`define EXEC_CFU_BGEU       5'b00110
`define EXEC_CFU_JALI       5'b10000    // Unconditional, bits 4:3 = 10
`define EXEC_CFU_JALR       5'b10001
`define EXEC_CFU_TAKEN      5'b11000    // Resolved branch codes
`define EXEC_CFU_NOT_TAKEN  5'b11001

// Load/store micro-op bits ----------
`define EXEC_LSU_LOAD_BIT   3           // Set for loads
`define EXEC_LSU_STORE_BIT  4           // Set for stores

`endif

// File: logic/exec_pkg.sv
// --------------------
// Types shared across the execute stage.
// Struct field order is the bus bit order, rd in the MSBs.
// --------------------
`include "exec_stage_settings.svh"

package exec_pkg;

    // Plain vectors ----------
    typedef logic [`EXEC_XLEN-1:0] word_t;      // One data word
    typedef logic [4:0]            reg_addr_t;  // Register index
    typedef logic [4:0]            uop_t;       // Micro-op code
    typedef logic [3:0]            fu_sel_t;    // One-hot unit select

    // Request from decode ----------
    typedef struct packed {
        reg_addr_t   rd;                        // Destination register
        word_t       opr_a;                     // Operand A
        word_t       opr_b;                     // Operand B
        word_t       opr_c;                     // Operand C
        uop_t        uop;                       // Micro-op code
        fu_sel_t     fu;                        // Functional unit
        logic        trap;                      // Trap raised upstream
        logic [1:0]  size;                      // Instruction size
        logic [31:0] instr;                     // Instruction word
    } exec_req_t;

    // Result to writeback ----------
    typedef struct packed {
        reg_addr_t   rd;                        // Destination register
        word_t       opr_a;                     // Result or address
        word_t       opr_b;                     // Store data or trap cause
        uop_t        uop;                       // Resolved micro-op
        fu_sel_t     fu;                        // Functional unit
        logic        trap;                      // Trap flag
        logic [1:0]  size;                      // Instruction size
        logic [31:0] instr;                     // Instruction word
    } exec_res_t;

    // Forwarding for the register in flight
    typedef struct packed {
        reg_addr_t   rd;                        // Register being written
        word_t       wdata;                     // ALU write data
        logic        load;                      // Load in flight, data not ready
        logic        csr;                       // CSR op in flight
    } exec_fwd_t;

endpackage

// File: logic/exec_alu.sv
// --------------------
// Single-cycle integer ALU. Result is zero when the ALU is not selected.
// Shifts use only the low 5 bits of operand B.
// The lt flag follows the signedness of SLTU and BLTU/BGEU.
// --------------------
`timescale 1ns/10ps
`include "exec_stage_settings.svh"

module exec_alu (
    input  exec_pkg::exec_req_t i_req,      // Request from decode
    output exec_pkg::word_t     o_result,   // ALU result
    output exec_pkg::word_t     o_sum,      // A + B, always valid
    output logic                o_lt,       // A < B
    output logic                o_eq        // A == B
);
    import exec_pkg::*;

    // Operation decode --------------------
    logic  fu_alu;
    logic  fu_cfu;
    logic  op_add;
    logic  op_sub;
    logic  op_xor;
    logic  op_or;
    logic  op_and;
    logic  op_sll;
    logic  op_srl;
    logic  op_sra;
    logic  op_slt;
    logic  op_sltu;
    logic  cmp_unsigned;

    word_t lhs;
    word_t rhs;
    word_t diff;
    word_t sll_res;
    word_t srl_res;
    word_t sra_res;
    logic  [4:0] shamt;

    assign fu_alu  = i_req.fu[`EXEC_FU_ALU];
    assign fu_cfu  = i_req.fu[`EXEC_FU_CFU];

    assign op_add  = fu_alu && (i_req.uop == `EXEC_ALU_ADD);
    assign op_sub  = fu_alu && (i_req.uop == `EXEC_ALU_SUB);
    assign op_xor  = fu_alu && (i_req.uop == `EXEC_ALU_XOR);
    assign op_or   = fu_alu && (i_req.uop == `EXEC_ALU_OR);
    assign op_and  = fu_alu && (i_req.uop == `EXEC_ALU_AND);
    assign op_sll  = fu_alu && (i_req.uop == `EXEC_ALU_SLL);
    assign op_srl  = fu_alu && (i_req.uop == `EXEC_ALU_SRL);
    assign op_sra  = fu_alu && (i_req.uop == `EXEC_ALU_SRA);
    assign op_slt  = fu_alu && (i_req.uop == `EXEC_ALU_SLT);
    assign op_sltu = fu_alu && (i_req.uop == `EXEC_ALU_SLTU);

    // Unsigned for SLTU and the unsigned branches
    assign cmp_unsigned = op_sltu ||
                          fu_cfu && (i_req.uop == `EXEC_CFU_BLTU ||
                                     i_req.uop == `EXEC_CFU_BGEU);

    // Datapath --------------------
    assign lhs     = i_req.opr_a;
    assign rhs     = i_req.opr_b;
    assign shamt   = rhs[4:0];                          // RV32 shift range

    assign o_sum   = lhs + rhs;                         // Shared with LSU and jalr
    assign diff    = lhs - rhs;
    assign sll_res = lhs << shamt;
    assign srl_res = lhs >> shamt;
    assign sra_res = word_t'($signed(lhs) >>> shamt);   // Sign fill

    assign o_eq    = (lhs == rhs);
    assign o_lt    = cmp_unsigned ? (lhs < rhs) : ($signed(lhs) < $signed(rhs));

    // One-hot AND-OR result mux
    assign o_result = {`EXEC_XLEN{op_add}}  & o_sum       |
                      {`EXEC_XLEN{op_sub}}  & diff        |
                      {`EXEC_XLEN{op_xor}}  & (lhs ^ rhs) |
                      {`EXEC_XLEN{op_or}}   & (lhs | rhs) |
                      {`EXEC_XLEN{op_and}}  & (lhs & rhs) |
                      {`EXEC_XLEN{op_sll}}  & sll_res     |
                      {`EXEC_XLEN{op_srl}}  & srl_res     |
                      {`EXEC_XLEN{op_sra}}  & sra_res     |
                      {{(`EXEC_XLEN-1){1'b0}}, (op_slt || op_sltu) && o_lt};

    // Decode relies on at most one unit being selected upstream
    always_comb begin
        assert ($onehot0(i_req.fu))
            else $error("exec_alu: unit select not one-hot: %b", i_req.fu);
    end

endmodule

// File: logic/exec_branch.sv
// --------------------
// Branch resolution and jump target.
// Compare flags come from the ALU, which picks the signedness.
// --------------------
`timescale 1ns/10ps
`include "exec_stage_settings.svh"

module exec_branch (
    input  exec_pkg::exec_req_t i_req,      // Request from decode
    input  exec_pkg::word_t     i_sum,      // A + B from the ALU
    input  logic                i_lt,       // A < B
    input  logic                i_eq,       // A == B
    output exec_pkg::uop_t      o_uop,      // Resolved micro-op
    output exec_pkg::word_t     o_target    // Jump or branch target
);
    import exec_pkg::*;

    logic  fu_cfu;
    logic  cond;
    logic  jalr;
    logic  taken;
    word_t base;

    assign fu_cfu = i_req.fu[`EXEC_FU_CFU];
    assign cond   = fu_cfu && (i_req.uop[4:3] == 2'b00);   // Conditional group
    assign jalr   = fu_cfu && (i_req.uop == `EXEC_CFU_JALR);

    // Taken condition --------------------
    assign taken = (i_req.uop == `EXEC_CFU_BEQ)  &&  i_eq ||
                   (i_req.uop == `EXEC_CFU_BNE)  && !i_eq ||
                   (i_req.uop == `EXEC_CFU_BLT)  &&  i_lt ||
                   (i_req.uop == `EXEC_CFU_BGE)  && !i_lt ||
                   (i_req.uop == `EXEC_CFU_BLTU) &&  i_lt ||   // lt already unsigned
                   (i_req.uop == `EXEC_CFU_BGEU) && !i_lt;

    // Jumps keep their own code
    assign o_uop = !cond ? i_req.uop :
                   taken ? `EXEC_CFU_TAKEN : `EXEC_CFU_NOT_TAKEN;

    // Target --------------------
    // jalr adds rs1 and the offset, all others get a precomputed C
    assign base     = jalr ? i_sum : i_req.opr_c;
    assign o_target = {base[`EXEC_XLEN-1:1], 1'b0};         // Halfword aligned

endmodule

// File: logic/exec_result_select.sv
// --------------------
// Builds the result word for the output register.
// A trap overrides operand B with the cause held in rd.
// Unselected units contribute zero.
// --------------------
`timescale 1ns/10ps
`include "exec_stage_settings.svh"

module exec_result_select (
    input  exec_pkg::exec_req_t i_req,          // Request from decode
    input  exec_pkg::word_t     i_alu_result,   // ALU result
    input  exec_pkg::word_t     i_sum,          // Address sum
    input  exec_pkg::uop_t      i_cfu_uop,      // Branch-resolved uop
    input  exec_pkg::word_t     i_target,       // Jump target
    output exec_pkg::exec_res_t o_res           // Next result
);
    import exec_pkg::*;

    logic  fu_alu;
    logic  fu_lsu;
    logic  fu_cfu;
    logic  fu_csr;
    word_t opr_a;
    word_t opr_b;
    word_t cause;

    assign fu_alu = i_req.fu[`EXEC_FU_ALU];
    assign fu_lsu = i_req.fu[`EXEC_FU_LSU];
    assign fu_cfu = i_req.fu[`EXEC_FU_CFU];
    assign fu_csr = i_req.fu[`EXEC_FU_CSR];

    // Operand A --------------------
    assign opr_a = {`EXEC_XLEN{fu_alu}} & i_alu_result |
                   {`EXEC_XLEN{fu_lsu}} & i_sum        |   // Memory address
                   {`EXEC_XLEN{fu_cfu}} & i_target     |
                   {`EXEC_XLEN{fu_csr}} & i_req.opr_a;     // CSR write value

    // Operand B, ALU and CFU give zero
    assign cause = word_t'(i_req.rd);                      // Zero-extended
    assign opr_b = i_req.trap ? cause :
                   {`EXEC_XLEN{fu_lsu}} & i_req.opr_c |    // Store data
                   {`EXEC_XLEN{fu_csr}} & i_req.opr_c;     // CSR address

    // Assemble --------------------
    always_comb begin
        o_res       = '0;
        o_res.rd    = i_req.rd;
        o_res.opr_a = opr_a;
        o_res.opr_b = opr_b;
        o_res.uop   = fu_cfu ? i_cfu_uop : i_req.uop;  // TAKEN/NOT_TAKEN for branches
        o_res.fu    = i_req.fu;
        o_res.trap  = i_req.trap;
        o_res.size  = i_req.size;
        o_res.instr = i_req.instr;
    end

endmodule

// File: logic/exec_pipe_reg.sv
// --------------------
// Single-entry output register with valid/busy handshake.
// Busy is combinational from the downstream busy.
// Flush drops valid and leaves the payload as is.
// --------------------
`timescale 1ns/10ps

module exec_pipe_reg (
    input  logic                g_clk,      // Clock
    input  logic                i_reset,    // Sync reset, active high
    input  logic                i_flush,    // Drop held result
    input  exec_pkg::exec_res_t i_res,      // Result from this stage
    input  logic                i_valid,    // i_res valid
    output logic                o_busy,     // Cannot accept this cycle
    output exec_pkg::exec_res_t o_res,      // Held result
    output logic                o_valid,    // o_res valid
    input  logic                i_busy      // Downstream stall
);
    import exec_pkg::*;

    exec_res_t res_q;
    logic      valid_q;

    // Stall only when holding something the next stage won't take
    assign o_busy  = valid_q && i_busy;
    assign o_res   = res_q;
    assign o_valid = valid_q;

    // Control --------------------
    always_ff @(posedge g_clk) begin
        if (i_reset || i_flush) begin
            valid_q <= 1'b0;
        end else if (!o_busy) begin
            valid_q <= i_valid;             // Refill or drain
        end
    end

    // Payload register
    always_ff @(posedge g_clk) begin
        if (i_valid && !o_busy) begin
            res_q <= i_res;
        end
    end

    // Decode must hold a stalled request until it is taken
    a_in_stable : assert property (
        @(posedge g_clk) disable iff (i_reset)
        (i_valid && o_busy) |=> $stable(i_res)
    ) else $error("exec_pipe_reg: request changed while stalled");

endmodule

// File: logic/exec_stage.sv
// --------------------
// Execute stage top. One result in flight, no multi-cycle units.
// o_fwd is combinational from i_req, valid or not.
// --------------------
`timescale 1ns/10ps
`include "exec_stage_settings.svh"

module exec_stage (
    input  logic                g_clk,          // Clock
    input  logic                i_reset,        // Sync reset, active high
    input  logic                i_flush,        // Flush output register
    input  exec_pkg::exec_req_t i_req,          // Decoded micro-op
    input  logic                i_req_valid,    // i_req valid
    output logic                o_req_busy,     // Stage stalled
    output exec_pkg::exec_res_t o_res,          // Result to writeback
    output logic                o_res_valid,    // o_res valid
    input  logic                i_res_busy,     // Writeback stalled
    output exec_pkg::exec_fwd_t o_fwd           // Forwarding info
);
    import exec_pkg::*;

    word_t     alu_result;
    word_t     alu_sum;
    logic      alu_lt;
    logic      alu_eq;
    uop_t      cfu_uop;
    word_t     cfu_target;
    exec_res_t next_res;

    // Units --------------------
    exec_alu u_alu (
        .i_req      (i_req),
        .o_result   (alu_result),
        .o_sum      (alu_sum),
        .o_lt       (alu_lt),
        .o_eq       (alu_eq)
    );

    exec_branch u_branch (
        .i_req      (i_req),
        .i_sum      (alu_sum),      // jalr base
        .i_lt       (alu_lt),
        .i_eq       (alu_eq),
        .o_uop      (cfu_uop),
        .o_target   (cfu_target)
    );

    exec_result_select u_select (
        .i_req          (i_req),
        .i_alu_result   (alu_result),
        .i_sum          (alu_sum),
        .i_cfu_uop      (cfu_uop),
        .i_target       (cfu_target),
        .o_res          (next_res)
    );

    exec_pipe_reg u_pipe_reg (
        .g_clk      (g_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_res      (next_res),
        .i_valid    (i_req_valid),  // Loads only when not busy
        .o_busy     (o_req_busy),
        .o_res      (o_res),
        .o_valid    (o_res_valid),
        .i_busy     (i_res_busy)
    );

    // Forwarding --------------------
    assign o_fwd.rd    = i_req.rd;
    assign o_fwd.wdata = alu_result;                    // Zero for non-ALU ops
    assign o_fwd.load  = i_req.fu[`EXEC_FU_LSU] && i_req.uop[`EXEC_LSU_LOAD_BIT];
    assign o_fwd.csr   = i_req.fu[`EXEC_FU_CSR];

endmodule

// File: tb/tb_exec_stage.sv
// --------------------
// Testbench for exec_stage. One result in flight at a time.
// Inputs change 5 ns after the rising edge, outputs sampled on the edge.
// Random back-pressure only while busy_en is set.
// --------------------
`timescale 1ns/10ps
`include "exec_stage_settings.svh"

module tb_exec_stage;
    import exec_pkg::*;

    localparam int   TIMEOUT = 200;             // Cycles allowed per wait
    localparam uop_t ALU_OPS [10] = '{`EXEC_ALU_ADD, `EXEC_ALU_SUB, `EXEC_ALU_XOR,
        `EXEC_ALU_OR, `EXEC_ALU_AND, `EXEC_ALU_SLL, `EXEC_ALU_SRL, `EXEC_ALU_SRA,
        `EXEC_ALU_SLT, `EXEC_ALU_SLTU};
    localparam uop_t CFU_OPS [8] = '{`EXEC_CFU_BEQ, `EXEC_CFU_BNE, `EXEC_CFU_BLT,
        `EXEC_CFU_BGE, `EXEC_CFU_BLTU, `EXEC_CFU_BGEU, `EXEC_CFU_JALI, `EXEC_CFU_JALR};

    logic        g_clk;
    logic        i_reset;
    logic        i_flush;
    logic        i_req_valid;
    logic        o_req_busy;
    logic        o_res_valid;
    logic        i_res_busy;
    exec_req_t   i_req;
    exec_res_t   o_res;
    exec_fwd_t   o_fwd;

    exec_res_t   exp_q[$];                      // Expected results in arrival order
    exec_res_t   held_res;                      // o_res seen on a stalled edge
    logic        held_busy;
    logic        busy_en;                       // Random writeback stalls on
    logic [31:0] rng;                           // Stimulus generator state
    logic [31:0] busy_rng;                      // Stall generator state
    string       test_name;

    exec_stage dut0 (.*);

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;             // 100 ns period
    end

    // Reference model --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic word_t alu_ref(input exec_req_t r);
        if (!r.fu[`EXEC_FU_ALU])
            return '0;                          // Zero when ALU unselected
        case (r.uop)
            `EXEC_ALU_ADD:  return r.opr_a + r.opr_b;
            `EXEC_ALU_SUB:  return r.opr_a - r.opr_b;
            `EXEC_ALU_XOR:  return r.opr_a ^ r.opr_b;
            `EXEC_ALU_OR:   return r.opr_a | r.opr_b;
            `EXEC_ALU_AND:  return r.opr_a & r.opr_b;
            `EXEC_ALU_SLL:  return r.opr_a << r.opr_b[4:0];
            `EXEC_ALU_SRL:  return r.opr_a >> r.opr_b[4:0];
            `EXEC_ALU_SRA:  return $signed(r.opr_a) >>> r.opr_b[4:0];
            `EXEC_ALU_SLT:  return word_t'($signed(r.opr_a) < $signed(r.opr_b));
            `EXEC_ALU_SLTU: return word_t'(r.opr_a < r.opr_b);
            default:        return '0;
        endcase
    endfunction

    function automatic uop_t branch_ref(input exec_req_t r);
        logic taken;
        case (r.uop)
            `EXEC_CFU_BEQ:  taken = (r.opr_a == r.opr_b);
            `EXEC_CFU_BNE:  taken = (r.opr_a != r.opr_b);
            `EXEC_CFU_BLT:  taken = ($signed(r.opr_a) < $signed(r.opr_b));
            `EXEC_CFU_BGE:  taken = ($signed(r.opr_a) >= $signed(r.opr_b));
            `EXEC_CFU_BLTU: taken = (r.opr_a < r.opr_b);
            `EXEC_CFU_BGEU: taken = (r.opr_a >= r.opr_b);
            default:        return r.uop;       // Jumps keep their code
        endcase
        return taken ? `EXEC_CFU_TAKEN : `EXEC_CFU_NOT_TAKEN;
    endfunction

    function automatic exec_res_t exec_model(input exec_req_t r);
        exec_res_t e;
        e = '{rd: r.rd, opr_a: '0, opr_b: '0, uop: r.uop, fu: r.fu, trap: r.trap,
              size: r.size, instr: r.instr};
        if (r.fu[`EXEC_FU_ALU])
            e.opr_a = alu_ref(r);
        if (r.fu[`EXEC_FU_LSU]) begin
            e.opr_a = r.opr_a + r.opr_b;        // Address
            e.opr_b = r.opr_c;                  // Store data
        end
        if (r.fu[`EXEC_FU_CFU]) begin
            e.uop      = branch_ref(r);
            e.opr_a    = (r.uop == `EXEC_CFU_JALR) ? r.opr_a + r.opr_b : r.opr_c;
            e.opr_a[0] = 1'b0;                  // Target bit 0 cleared
        end
        if (r.fu[`EXEC_FU_CSR]) begin
            e.opr_a = r.opr_a;
            e.opr_b = r.opr_c;
        end
        if (r.trap)
            e.opr_b = word_t'(r.rd);            // Zero-extended cause
        return e;
    endfunction

    function automatic exec_fwd_t fwd_model(input exec_req_t r);
        return '{rd: r.rd, wdata: alu_ref(r),
                 load: r.fu[`EXEC_FU_LSU] && r.uop[`EXEC_LSU_LOAD_BIT],
                 csr: r.fu[`EXEC_FU_CSR]};
    endfunction

    // Stimulus helpers --------------------
    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic exec_req_t rand_req(input int unit, input uop_t uop);
        exec_req_t r;
        r.rd    = 5'(next_rand());
        r.opr_a = next_rand();
        r.opr_b = next_rand();
        r.opr_c = next_rand();
        r.uop   = uop;
        r.fu    = 4'(1 << unit);                // One-hot select
        r.trap  = 1'b0;
        r.size  = 2'(next_rand());
        r.instr = next_rand();
        return r;
    endfunction

    // Cycles through all four units
    function automatic exec_req_t mixed_req(input int n);
        case (n % 4)
            0:       return rand_req(`EXEC_FU_ALU, ALU_OPS[(n / 4) % 10]);
            1:       return rand_req(`EXEC_FU_LSU, 5'(1 << (`EXEC_LSU_LOAD_BIT + n / 4 % 2)));
            2:       return rand_req(`EXEC_FU_CFU, CFU_OPS[(n / 4) % 8]);
            default: return rand_req(`EXEC_FU_CSR, 5'(n));
        endcase
    endfunction

    task automatic check_value(input string what, input logic [149:0] exp,
                               input logic [149:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch on %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out in %s waiting for %s", test_name, what);
        $display("=== FAIL ===");
        $fatal(1, "Wait did not finish");
    endtask

    task automatic drive_busy();
        if (busy_en) begin
            busy_rng   = xorshift(busy_rng);
            i_res_busy = busy_rng[3];           // Stall about half the cycles
        end
    endtask

    // Holds the request until the edge that takes it
    task automatic send(input exec_req_t r);
        int   cycles;
        logic taken;
        i_req       = r;
        i_req_valid = 1'b1;
        cycles      = 0;
        taken       = 1'b0;
        #1;
        check_value("forwarding", 150'(fwd_model(r)), 150'(o_fwd));
        while (!taken) begin
            @(posedge g_clk);
            taken = !o_req_busy;                // Transfer on this edge
            #5;
            drive_busy();
            cycles++;
            if (cycles > TIMEOUT)
                report_timeout("request accept");
        end
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        busy_en    = 1'b0;
        i_res_busy = 1'b0;
        cycles     = 0;
        while (exp_q.size() != 0 || o_res_valid) begin
            @(posedge g_clk);
            #5;
            cycles++;
            if (cycles > TIMEOUT)
                report_timeout("results to drain");
        end
    endtask

    // Scoreboard --------------------
    always @(posedge g_clk) begin
        if (i_reset || i_flush) begin
            exp_q.delete();                     // Held result is dropped
            held_busy = 1'b0;
        end else begin
            check_value("busy", 150'(o_res_valid && i_res_busy), 150'(o_req_busy));
            if (held_busy)
                check_value("held result", 150'(held_res), 150'(o_res));
            if (o_res_valid && !i_res_busy) begin
                if (exp_q.size() == 0) begin
                    $display("Result came out with no request pending in %s", test_name);
                    $display("=== FAIL ===");
                    $fatal(1, "Unexpected result");
                end else begin
                    check_value("result", 150'(exp_q.pop_front()), 150'(o_res));
                end
            end
            if (i_req_valid && !o_req_busy)
                exp_q.push_back(exec_model(i_req));
            held_busy = o_res_valid && i_res_busy;
            held_res  = o_res;
        end
    end

    // Test sequence --------------------
    initial begin
        int        i;
        exec_req_t r;
        i_reset     = 1'b1;
        i_flush     = 1'b0;
        i_req       = '0;
        i_req_valid = 1'b0;
        i_res_busy  = 1'b0;
        busy_en     = 1'b0;
        rng         = 32'h8175_aa61;
        busy_rng    = 32'h8175_aa61;
        test_name   = "reset";
        repeat (3) @(posedge g_clk);
        #5;
        i_reset = 1'b0;

        test_name = "alu";
        for (i = 0; i < 40; i++)
            send(rand_req(`EXEC_FU_ALU, ALU_OPS[i % 10]));
        drain();

        test_name = "branch";
        for (i = 0; i < 24; i++) begin
            r = rand_req(`EXEC_FU_CFU, CFU_OPS[i % 6]);
            if (i / 6 == 1)
                r.opr_b = r.opr_a;                          // Equal operands
            if (i / 6 == 2)
                r.opr_a = {~r.opr_b[31], r.opr_a[30:0]};    // Signs differ
            send(r);
        end
        for (i = 0; i < 8; i++)
            send(rand_req(`EXEC_FU_CFU, CFU_OPS[6 + i % 2]));   // JALI, JALR
        drain();

        test_name = "load/store/csr";
        for (i = 0; i < 24; i++) begin
            case (i % 3)
                0:       r = rand_req(`EXEC_FU_LSU, 5'(1 << `EXEC_LSU_LOAD_BIT));
                1:       r = rand_req(`EXEC_FU_LSU, 5'(1 << `EXEC_LSU_STORE_BIT));
                default: r = rand_req(`EXEC_FU_CSR, 5'(next_rand()));
            endcase
            send(r);
        end
        drain();

        test_name = "trap";
        for (i = 0; i < 8; i++) begin
            r      = mixed_req(i);              // Every unit, defined codes
            r.trap = 1'b1;
            send(r);
        end
        drain();

        test_name = "back-pressure";
        busy_en   = 1'b1;
        for (i = 0; i < 64; i++)
            send(mixed_req(i));
        drain();

        test_name  = "flush";
        i_res_busy = 1'b1;                      // Keep the result parked
        send(mixed_req(5));
        i_flush = 1'b1;
        @(posedge g_clk);
        #5;
        i_flush = 1'b0;
        check_value("valid after flush", 150'(1'b0), 150'(o_res_valid));
        i_res_busy = 1'b0;
        send(mixed_req(6));                     // Stage runs again
        drain();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: exec_stage.f
+incdir+.
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_result_select.sv
logic/exec_pipe_reg.sv
logic/exec_stage.sv
tb/tb_exec_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
# A $fatal in the testbench gives a non-zero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    -f exec_stage.f \
    --top-module tb_exec_stage \
    -o tb_exec_stage
./obj_dir/tb_exec_stage
